// File: la_config.svh
/*
  logic analyzer capture configuration
  stream, counter and timestamp widths, trigger sources and APB offsets
*/

`ifndef LA_CONFIG_SVH
`define LA_CONFIG_SVH

// sample, counter and timestamp widths
`define LA_DW 8
`define LA_CW 16
`define LA_TW 32

// trigger sources: bit 0 detector, bit 1 software
`define LA_TN 2

// register offsets, one 32-bit word each
`define LA_A_CTRL 8'h00
`define LA_A_CFG  8'h04
`define LA_A_TCFG 8'h08
`define LA_A_PRE  8'h0C
`define LA_A_PST  8'h10
`define LA_A_STAT 8'h14
`define LA_A_SPRE 8'h18
`define LA_A_SPST 8'h1C
`define LA_A_TACQ 8'h20
`define LA_A_TTRG 8'h24
`define LA_A_TSTP 8'h28
`define LA_A_TNOW 8'h2C
`define LA_A_IRQ  8'h30

`endif

// File: la_pkg.sv
/*
  logic analyzer types
  sample struct, trigger config word and APB requester bundle
*/

`default_nettype none

`include "la_config.svh"

package la_pkg;

  //////////////////////////////
  // stream sample
  //////////////////////////////

  // one sample plus end-of-record marker
  typedef struct packed {
    logic [`LA_DW-1:0] data;
    logic              last;
  } la_smp_t;

  //////////////////////////////
  // trigger config word
  //////////////////////////////

  // same 16 bits, read by mode
  typedef union packed {
    // pattern match: masked sample == masked value
    struct packed {
      logic [`LA_DW-1:0] mask;
      logic [`LA_DW-1:0] value;
    } pat;
    // edge detect, per bit 1 rising and 0 falling
    struct packed {
      logic [`LA_DW-1:0] mask;
      logic [`LA_DW-1:0] rise;
    } edg;
  } la_tcfg_u;

  //////////////////////////////
  // APB requester side
  //////////////////////////////

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } la_apb_req_t;

endpackage

`default_nettype wire

// File: la_trg.sv
/*
  trigger detector
  checks each accepted sample against a masked pattern or masked edges
*/

`timescale 1ns/1ps
`default_nettype none

`include "la_config.svh"

module la_trg
  import la_pkg::*;
(
  input  logic     sti,
  input  logic     ctl_rst,
  // sample and its transfer qualifier
  input  la_smp_t  din,
  input  logic     xfer,
  // configuration
  input  la_tcfg_u tcfg,
  input  logic     tmode,
  // detection, same cycle as the transfer
  output logic     det
);

  // previous transferred sample
  logic [`LA_DW-1:0] prv_data;
  logic              prv_vld;

  // per bit transitions since last transfer
  logic [`LA_DW-1:0] rise_d;
  logic [`LA_DW-1:0] fall_d;
  logic [`LA_DW-1:0] edg_sel;

  logic pat_hit;
  logic edg_hit;

  //////////////////////////////
  // history
  //////////////////////////////

  // sample history, only meaningful once prv_vld is set
  always_ff @(posedge sti) begin
    if (xfer) begin
      prv_data <= din.data;
    end
  end

  // no edge on the first transfer after reset
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      prv_vld <= 1'b0;
    end else if (xfer) begin
      prv_vld <= 1'b1;
    end
  end

  //////////////////////////////
  // compare
  //////////////////////////////

  // masked bits equal, unmasked bits ignored
  assign pat_hit = ~|((din.data ^ tcfg.pat.value) & tcfg.pat.mask);

  assign rise_d  = din.data & ~prv_data;
  assign fall_d  = ~din.data & prv_data;
  // pick direction per bit
  assign edg_sel = (rise_d & tcfg.edg.rise) | (fall_d & ~tcfg.edg.rise);
  assign edg_hit = prv_vld & |(edg_sel & tcfg.edg.mask);

  // mode 0 pattern, 1 edge
  assign det = xfer & (tmode ? edg_hit : pat_hit);

  // an edge hit needs a sample that differs from the last one
  a_edg_chg: assert property (@(posedge sti) disable iff (ctl_rst)
    (det && tmode) |-> (din.data != prv_data));

endmodule

`default_nettype wire

// File: la_acq.sv
/*
  acquire controller
  start/trigger/stop status, pre and post counters, timestamps
  and the registered output stage of the capture stream
*/

`timescale 1ns/1ps
`default_nettype none

`include "la_config.svh"

module la_acq
  import la_pkg::*;
(
  input  logic              sti,
  input  logic              ctl_rst,
  // input stream
  input  la_smp_t           din,
  input  logic              din_valid,
  output logic              din_ready,
  // output stream
  output la_smp_t           dout,
  output logic              dout_valid,
  input  logic              dout_ready,
  // detector hit
  input  logic              det,
  // control strobes
  input  logic              ctl_acq,
  input  logic              ctl_stp,
  input  logic              ctl_trg_sw,
  // configuration
  input  logic [`LA_TN-1:0] cfg_trg,
  input  logic              cfg_con,
  input  logic              cfg_aut,
  input  logic [`LA_CW-1:0] cfg_pre,
  input  logic [`LA_CW-1:0] cfg_pst,
  input  logic [`LA_TW-1:0] cts,
  // status
  output logic              sts_acq,
  output logic              sts_trg,
  output logic [`LA_CW-1:0] sts_pre,
  output logic [`LA_CW-1:0] sts_pst,
  output logic [`LA_TW-1:0] cts_acq,
  output logic [`LA_TW-1:0] cts_trg,
  output logic [`LA_TW-1:0] cts_stp,
  // events
  output logic              ev_trg,
  output logic              ev_stp
);

  logic              xfer;
  logic              ena_pre;
  logic              stp_req;
  logic [`LA_TN-1:0] trg_src;
  logic              trg;
  logic              stp_pst;
  logic              sts_stp;
  logic              acq_go;
  logic              pre_end;
  logic [`LA_CW-1:0] nxt_pre;
  logic [`LA_CW-1:0] nxt_pst;

  //////////////////////////////
  // handshake and decisions
  //////////////////////////////

  // input moves whenever the output slot frees up
  assign din_ready = dout_ready | ~dout_valid;
  assign xfer      = din_valid & din_ready;

  assign nxt_pre = sts_pre + 1'b1;
  assign nxt_pst = sts_pst + 1'b1;

  // bit 0 detector, bit 1 software
  assign trg_src = {ctl_trg_sw, det};
  assign trg     = |(trg_src & cfg_trg) & sts_acq & ena_pre & ~sts_trg;

  // post count ends on a sample counted as post trigger
  assign stp_pst = (sts_trg | trg) & (nxt_pst == cfg_pst) & ~cfg_con;

  // every stop lands on an accepted sample so the record closes with last
  // a software stop waits in stp_req for the next transfer
  assign sts_stp = sts_acq & xfer & (ctl_stp | stp_req | din.last | stp_pst);

  // pre count reached on this transfer
  assign pre_end = sts_acq & xfer & ~sts_trg & (nxt_pre == cfg_pre);

  // restart allowed on the stopping cycle
  assign acq_go = ctl_acq & (~sts_acq | sts_stp);

  assign ev_trg = trg;
  assign ev_stp = sts_stp;

  //////////////////////////////
  // status and counters
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      ena_pre <= 1'b0;
      stp_req <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      cts_acq <= '0;
      cts_trg <= '0;
      cts_stp <= '0;
    end else begin
      // counting, trigger sample goes to post
      if (sts_acq && xfer) begin
        if (!sts_trg && !trg) begin
          sts_pre <= nxt_pre;
        end
        if (sts_trg || trg) begin
          sts_pst <= nxt_pst;
        end
      end
      if (pre_end) begin
        ena_pre <= 1'b1;
      end
      if (trg) begin
        sts_trg <= 1'b1;
        cts_trg <= cts;
      end
      // stop, or remember a software stop
      if (sts_stp) begin
        sts_acq <= 1'b0;
        stp_req <= 1'b0;
        cts_stp <= cts;
      end else if (sts_acq && ctl_stp) begin
        stp_req <= 1'b1;
      end
      // start overrides the above
      if (acq_go) begin
        sts_acq <= 1'b1;
        sts_trg <= cfg_aut;
        ena_pre <= ~|cfg_pre;
        stp_req <= 1'b0;
        sts_pre <= '0;
        sts_pst <= '0;
        cts_acq <= cts;
        // automatic start is its own trigger
        if (cfg_aut) begin
          cts_trg <= cts;
        end
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      dout_valid <= 1'b0;
    end else if (din_ready) begin
      dout_valid <= sts_acq & din_valid;
    end
  end

  // last marks the stop sample, input last included
  always_ff @(posedge sti) begin
    if (sts_acq && xfer) begin
      dout.data <= din.data;
      dout.last <= sts_stp;
    end
  end

  // held sample must not change until taken
  a_dout_hold: assert property (@(posedge sti) disable iff (ctl_rst)
    (dout_valid && !dout_ready) |=> (dout_valid && $stable(dout)));

  // a held stop request belongs to a running acquisition
  a_req_run: assert property (@(posedge sti) disable iff (ctl_rst)
    stp_req |-> sts_acq);

endmodule

`default_nettype wire

// File: la_regs.sv
/*
  APB register bank
  configuration, control strobes, status readback, time counter
  and write-1-to-clear interrupt pending bits
*/

`timescale 1ns/1ps
`default_nettype none

`include "la_config.svh"

module la_regs
  import la_pkg::*;
(
  input  logic              sti,
  input  logic              ctl_rst,
  // APB completer
  input  la_apb_req_t       apb,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  // control strobes
  output logic              ctl_acq,
  output logic              ctl_stp,
  output logic              ctl_trg_sw,
  // configuration
  output logic [`LA_TN-1:0] cfg_trg,
  output logic              cfg_con,
  output logic              cfg_aut,
  output logic [`LA_CW-1:0] cfg_pre,
  output logic [`LA_CW-1:0] cfg_pst,
  output logic [`LA_TW-1:0] cts,
  output la_tcfg_u          tcfg,
  output logic              tmode,
  // status from the acquire block
  input  logic              sts_acq,
  input  logic              sts_trg,
  input  logic [`LA_CW-1:0] sts_pre,
  input  logic [`LA_CW-1:0] sts_pst,
  input  logic [`LA_TW-1:0] cts_acq,
  input  logic [`LA_TW-1:0] cts_trg,
  input  logic [`LA_TW-1:0] cts_stp,
  input  logic              ev_trg,
  input  logic              ev_stp,
  // interrupt
  output logic              irq
);

  logic        acc;
  logic        hit;
  logic        ro;
  logic        wr_ok;
  logic [1:0]  irq_pnd;
  logic [1:0]  irq_clr;

  //////////////////////////////
  // decode and read mux
  //////////////////////////////

  // zero wait states
  assign pready = 1'b1;
  assign acc    = apb.psel & apb.penable;

  always_comb begin
    prdata = '0;
    hit    = 1'b1;
    ro     = 1'b0;
    case (apb.paddr)
      // strobes only, reads as zero
      `LA_A_CTRL: prdata = '0;
      `LA_A_CFG:  prdata = 32'({cfg_aut, cfg_con, cfg_trg});
      `LA_A_TCFG: prdata = 32'({tmode, tcfg});
      `LA_A_PRE:  prdata = 32'(cfg_pre);
      `LA_A_PST:  prdata = 32'(cfg_pst);
      `LA_A_STAT: begin
        prdata = 32'({sts_trg, sts_acq});
        ro     = 1'b1;
      end
      `LA_A_SPRE: begin
        prdata = 32'(sts_pre);
        ro     = 1'b1;
      end
      `LA_A_SPST: begin
        prdata = 32'(sts_pst);
        ro     = 1'b1;
      end
      `LA_A_TACQ: begin
        prdata = 32'(cts_acq);
        ro     = 1'b1;
      end
      `LA_A_TTRG: begin
        prdata = 32'(cts_trg);
        ro     = 1'b1;
      end
      `LA_A_TSTP: begin
        prdata = 32'(cts_stp);
        ro     = 1'b1;
      end
      `LA_A_TNOW: begin
        prdata = 32'(cts);
        ro     = 1'b1;
      end
      `LA_A_IRQ:  prdata = 32'(irq_pnd);
      default:    hit    = 1'b0;
    endcase
  end

  // unmapped offset, or write to a status word
  assign pslverr = acc & (~hit | (apb.pwrite & ro));
  assign wr_ok   = acc & apb.pwrite & hit & ~ro;

  //////////////////////////////
  // configuration and strobes
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cfg_trg    <= '0;
      cfg_con    <= 1'b0;
      cfg_aut    <= 1'b0;
      cfg_pre    <= '0;
      cfg_pst    <= '0;
      tcfg       <= '0;
      tmode      <= 1'b0;
      ctl_acq    <= 1'b0;
      ctl_stp    <= 1'b0;
      ctl_trg_sw <= 1'b0;
    end else begin
      // strobes last one cycle, after the access phase
      ctl_acq    <= wr_ok && (apb.paddr == `LA_A_CTRL) && apb.pwdata[0];
      ctl_stp    <= wr_ok && (apb.paddr == `LA_A_CTRL) && apb.pwdata[1];
      ctl_trg_sw <= wr_ok && (apb.paddr == `LA_A_CTRL) && apb.pwdata[2];
      if (wr_ok) begin
        case (apb.paddr)
          `LA_A_CFG: begin
            cfg_trg <= apb.pwdata[`LA_TN-1:0];
            cfg_con <= apb.pwdata[2];
            cfg_aut <= apb.pwdata[3];
          end
          `LA_A_TCFG: begin
            tcfg  <= apb.pwdata[15:0];
            tmode <= apb.pwdata[16];
          end
          `LA_A_PRE: cfg_pre <= apb.pwdata[`LA_CW-1:0];
          `LA_A_PST: cfg_pst <= apb.pwdata[`LA_CW-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // time and interrupts
  //////////////////////////////

  // free-running time base
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cts <= '0;
    end else begin
      cts <= cts + 1'b1;
    end
  end

  // bit 0 trigger, bit 1 stop
  assign irq_clr = (wr_ok && (apb.paddr == `LA_A_IRQ)) ? apb.pwdata[1:0] : 2'b00;

  // a new event wins over a clear in the same cycle
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      irq_pnd <= '0;
    end else begin
      irq_pnd <= (irq_pnd & ~irq_clr) | {ev_stp, ev_trg};
    end
  end

  assign irq = |irq_pnd;

  // APB setup phase comes first
  a_apb_setup: assert property (@(posedge sti) disable iff (ctl_rst)
    $rose(apb.penable) |-> apb.psel);

endmodule

`default_nettype wire

// File: la_top.sv
/*
  logic analyzer capture top
  register bank, trigger detector and acquire controller
*/

`timescale 1ns/1ps
`default_nettype none

`include "la_config.svh"

module la_top
  import la_pkg::*;
(
  input  logic        sti,
  input  logic        ctl_rst,
  // APB
  input  la_apb_req_t apb,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // sample streams
  input  la_smp_t     din,
  input  logic        din_valid,
  output logic        din_ready,
  output la_smp_t     dout,
  output logic        dout_valid,
  input  logic        dout_ready,
  // interrupt
  output logic        irq
);

  // control and configuration
  logic              ctl_acq;
  logic              ctl_stp;
  logic              ctl_trg_sw;
  logic [`LA_TN-1:0] cfg_trg;
  logic              cfg_con;
  logic              cfg_aut;
  logic [`LA_CW-1:0] cfg_pre;
  logic [`LA_CW-1:0] cfg_pst;
  logic [`LA_TW-1:0] cts;
  la_tcfg_u          tcfg;
  logic              tmode;
  // status and events
  logic              sts_acq;
  logic              sts_trg;
  logic [`LA_CW-1:0] sts_pre;
  logic [`LA_CW-1:0] sts_pst;
  logic [`LA_TW-1:0] cts_acq;
  logic [`LA_TW-1:0] cts_trg;
  logic [`LA_TW-1:0] cts_stp;
  logic              ev_trg;
  logic              ev_stp;
  logic              det;

  la_regs i_la_regs (
    .sti, .ctl_rst,
    .apb, .prdata, .pready, .pslverr,
    .ctl_acq, .ctl_stp, .ctl_trg_sw,
    .cfg_trg, .cfg_con, .cfg_aut, .cfg_pre, .cfg_pst,
    .cts, .tcfg, .tmode,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst,
    .cts_acq, .cts_trg, .cts_stp,
    .ev_trg, .ev_stp,
    .irq
  );

  // detector sees every accepted sample, idle or not
  la_trg i_la_trg (
    .sti, .ctl_rst,
    .din,
    .xfer  (din_valid & din_ready),
    .tcfg, .tmode,
    .det
  );

  la_acq i_la_acq (
    .sti, .ctl_rst,
    .din, .din_valid, .din_ready,
    .dout, .dout_valid, .dout_ready,
    .det,
    .ctl_acq, .ctl_stp, .ctl_trg_sw,
    .cfg_trg, .cfg_con, .cfg_aut, .cfg_pre, .cfg_pst,
    .cts,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst,
    .cts_acq, .cts_trg, .cts_stp,
    .ev_trg, .ev_stp
  );

endmodule

`default_nettype wire

// File: la_tb.sv
/*
  logic analyzer capture testbench
  random sample stream with back-pressure, APB register tasks,
  a cycle model of the capture rules and per-transfer output checks
*/

`timescale 1ns/1ps
`default_nettype none

`include "la_config.svh"

module la_tb
  import la_pkg::*;
();

  // six tests, 400 cycles each
  localparam int MAX_CYC = 6 * 400;

  logic              sti;
  logic              ctl_rst;
  la_apb_req_t       apb;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  la_smp_t           din;
  logic              din_valid;
  logic              din_ready;
  la_smp_t           dout;
  logic              dout_valid;
  logic              dout_ready;
  logic              irq;

  // stimulus state
  logic [31:0]       lcg;
  la_apb_req_t       apb_q;
  logic              gen_on;
  logic              bp_on;
  logic              last_req;
  logic [`LA_DW-1:0] last_data;
  int                cyc;
  int                errs;
  int                errs_at;
  int                stream_errs;
  int                tests_ok;
  int                tests_bad;

  // capture model
  logic              m_acq;
  logic              m_trg;
  logic              m_ena;
  logic              m_sreq;
  logic              m_dv;
  logic              m_xfer;
  logic              m_prv_vld;
  logic [`LA_DW-1:0] m_prv;
  logic              s_acq;
  logic              s_stp;
  logic              s_sw;
  logic [`LA_TN-1:0] m_cfg_trg;
  logic              m_con;
  logic              m_aut;
  logic [`LA_CW-1:0] m_cfg_pre;
  logic [`LA_CW-1:0] m_cfg_pst;
  logic [`LA_CW-1:0] m_pre;
  logic [`LA_CW-1:0] m_pst;
  logic [`LA_DW-1:0] m_tmask;
  logic [`LA_DW-1:0] m_tval;
  logic              m_tmode;
  la_smp_t           exp_q[$];
  la_smp_t           last_out;
  int                n_out;
  int                n_last;
  int                n_idle;
  int                m_nacq;
  int                n_bp_all;
  int                n_out_all;

  la_top i_la_top (
    .sti, .ctl_rst,
    .apb, .prdata, .pready, .pslverr,
    .din, .din_valid, .din_ready,
    .dout, .dout_valid, .dout_ready,
    .irq
  );

  initial sti = 1'b0;
  always #4 sti = ~sti;

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic show_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("Fail at %0t ns: %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
    errs++;
  endtask

  task automatic show_problem(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errs++;
  endtask

  task automatic begin_test();
    errs_at = errs;
    n_out   = 0;
    n_last  = 0;
    n_idle  = 0;
    m_nacq  = 0;
  endtask

  task automatic end_test(input int num, input string name);
    if (errs == errs_at) begin
      tests_ok++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", num, name, errs - errs_at);
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // 32-bit LCG, upper half used
  function automatic logic [31:0] next_rand();
    lcg = lcg * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg[31:16]};
  endfunction

  // one clock: drive at the falling edge, then model the coming rising edge
  task automatic tick();
    logic [31:0] r;
    @(negedge sti);
    apb = apb_q;
    // producer holds its sample until it moves
    if (!din_valid || m_xfer) begin
      r = next_rand();
      if (gen_on && (r[1:0] != 2'b00)) begin
        din_valid = 1'b1;
        din.data  = r[15:8];
        din.last  = last_req;
        if (last_req) begin
          last_data = r[15:8];
          last_req  = 1'b0;
        end
      end else begin
        din_valid = 1'b0;
        din.last  = 1'b0;
      end
    end
    r = next_rand();
    dout_ready = bp_on ? (r[3:2] != 2'b00) : 1'b1;
    // inputs and outputs settled here
    #2;
    model_step();
  endtask

  //////////////////////////////
  // capture model
  //////////////////////////////

  task automatic model_step();
    logic    rdy;
    logic    xf;
    logic    hit;
    logic    det;
    logic    trg;
    logic    post;
    logic    stp_pst;
    logic    stop;
    logic    go;
    logic    pre_hit;
    la_smp_t e;
    int      i;
    rdy = dout_ready | ~m_dv;
    xf  = din_valid & rdy;
    // handshake
    if (din_ready !== rdy) begin
      show_mismatch("din_ready", {31'd0, din_ready}, {31'd0, rdy});
      stream_errs++;
    end
    if (dout_valid !== m_dv) begin
      show_mismatch("dout_valid", {31'd0, dout_valid}, {31'd0, m_dv});
      stream_errs++;
    end
    if (dout_valid && !dout_ready) begin
      n_bp_all++;
    end
    // output transfer against the queue head
    if (m_dv && dout_ready) begin
      if (exp_q.size() == 0) begin
        show_problem("output sample with nothing expected");
        stream_errs++;
      end else begin
        e = exp_q.pop_front();
        if (dout !== e) begin
          show_mismatch("dout", {23'd0, dout}, {23'd0, e});
          stream_errs++;
        end
        n_out++;
        n_out_all++;
        if (dout.last) begin
          n_last++;
        end
        last_out = dout;
      end
    end
    // detector, pattern or per-bit edge
    hit = 1'b0;
    if (m_tmode) begin
      for (i = 0; i < `LA_DW; i++) begin
        if (m_tmask[i] && m_prv_vld) begin
          if (m_tval[i] && !m_prv[i] && din.data[i]) begin
            hit = 1'b1;
          end
          if (!m_tval[i] && m_prv[i] && !din.data[i]) begin
            hit = 1'b1;
          end
        end
      end
    end else begin
      hit = ((din.data & m_tmask) == (m_tval & m_tmask));
    end
    det = xf & hit;
    // decisions from the state before the edge
    trg     = |({s_sw, det} & m_cfg_trg) && m_acq && m_ena && !m_trg;
    post    = m_trg | trg;
    stp_pst = post && (m_pst + 1'b1 == m_cfg_pst) && !m_con;
    stop    = m_acq && xf && (s_stp || m_sreq || din.last || stp_pst);
    go      = s_acq && (!m_acq || stop);
    pre_hit = m_acq && xf && !m_trg && (m_pre + 1'b1 == m_cfg_pre);
    // state update
    if (xf) begin
      m_prv     = din.data;
      m_prv_vld = 1'b1;
      if (!m_acq) begin
        n_idle++;
      end
    end
    if (m_acq && xf) begin
      e.data = din.data;
      e.last = stop;
      exp_q.push_back(e);
      m_nacq++;
      if (post) begin
        m_pst++;
      end else begin
        m_pre++;
      end
    end
    if (rdy) begin
      m_dv = m_acq & din_valid;
    end
    if (pre_hit) begin
      m_ena = 1'b1;
    end
    if (trg) begin
      m_trg = 1'b1;
    end
    if (stop) begin
      m_acq  = 1'b0;
      m_sreq = 1'b0;
    end else if (m_acq && s_stp) begin
      m_sreq = 1'b1;
    end
    if (go) begin
      m_acq  = 1'b1;
      m_trg  = m_aut;
      m_ena  = (m_cfg_pre == '0);
      m_sreq = 1'b0;
      m_pre  = '0;
      m_pst  = '0;
    end
    // register writes land at this edge, strobes one cycle later
    s_acq = 1'b0;
    s_stp = 1'b0;
    s_sw  = 1'b0;
    if (apb.psel && apb.penable && apb.pwrite) begin
      case (apb.paddr)
        `LA_A_CTRL: begin
          s_acq = apb.pwdata[0];
          s_stp = apb.pwdata[1];
          s_sw  = apb.pwdata[2];
        end
        `LA_A_CFG: begin
          m_cfg_trg = apb.pwdata[1:0];
          m_con     = apb.pwdata[2];
          m_aut     = apb.pwdata[3];
        end
        `LA_A_TCFG: begin
          m_tval  = apb.pwdata[7:0];
          m_tmask = apb.pwdata[15:8];
          m_tmode = apb.pwdata[16];
        end
        `LA_A_PRE: m_cfg_pre = apb.pwdata[15:0];
        `LA_A_PST: m_cfg_pst = apb.pwdata[15:0];
        default: ;
      endcase
    end
    m_xfer = xf;
  endtask

  //////////////////////////////
  // APB
  //////////////////////////////

  // setup then access, data and error sampled in the access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    apb_q.psel    = 1'b1;
    apb_q.penable = 1'b0;
    apb_q.pwrite  = wr;
    apb_q.paddr   = addr;
    apb_q.pwdata  = wdata;
    tick();
    apb_q.penable = 1'b1;
    tick();
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      show_problem("pready low in an access phase");
    end
    apb_q = '0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    if (err !== 1'b0) begin
      show_mismatch("pslverr", {31'd0, err}, 32'd0);
    end
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    if (err !== 1'b0) begin
      show_mismatch("pslverr", {31'd0, err}, 32'd0);
    end
  endtask

  task automatic read_check(input logic [7:0] addr, input string name,
                            input logic [31:0] exp);
    logic [31:0] rd;
    reg_read(addr, rd);
    if (rd !== exp) begin
      show_mismatch(name, rd, exp);
    end
  endtask

  //////////////////////////////
  // sequencing helpers
  //////////////////////////////

  task automatic wait_running();
    while (!m_acq) begin
      tick();
    end
  endtask

  task automatic wait_stopped();
    while (m_acq) begin
      tick();
    end
  endtask

  // stop offering, let the output stage empty
  task automatic drain_stream();
    gen_on = 1'b0;
    while (din_valid || m_dv) begin
      tick();
    end
  endtask

  // one record closed by exactly one last
  task automatic check_record();
    if (exp_q.size() != 0) begin
      show_problem("expected samples never came out");
    end
    if (n_out != m_nacq) begin
      show_mismatch("output count", n_out, m_nacq);
    end
    if (n_last != 1) begin
      show_mismatch("dout.last count", n_last, 1);
    end
    if (n_out > 0 && last_out.last !== 1'b1) begin
      show_mismatch("dout.last", {31'd0, last_out.last}, 32'd1);
    end
  endtask

  task automatic check_stamps();
    logic [31:0] t_acq;
    logic [31:0] t_trg;
    logic [31:0] t_stp;
    reg_read(`LA_A_TACQ, t_acq);
    reg_read(`LA_A_TTRG, t_trg);
    reg_read(`LA_A_TSTP, t_stp);
    if (!(t_acq <= t_trg && t_trg <= t_stp)) begin
      show_problem($sformatf("timestamps out of order %0d %0d %0d", t_acq, t_trg, t_stp));
    end
  endtask

  // cannot hang
  initial begin : watchdog
    cyc = 0;
    while (cyc < MAX_CYC) begin
      @(posedge sti);
      cyc++;
    end
    $display("Error: run exceeded %0d cycles", MAX_CYC);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin : main
    logic [31:0] rd;
    logic [31:0] t0;
    logic        err;
    ctl_rst    = 1'b1;
    apb        = '0;
    apb_q      = '0;
    din        = '0;
    din_valid  = 1'b0;
    dout_ready = 1'b1;
    lcg        = 32'h72d7;
    gen_on     = 1'b0;
    bp_on      = 1'b0;
    last_req   = 1'b0;
    last_data  = '0;
    {errs, errs_at, stream_errs, tests_ok, tests_bad} = '0;
    {n_out, n_last, n_idle, m_nacq, n_bp_all, n_out_all} = '0;
    {m_acq, m_trg, m_ena, m_sreq, m_dv, m_xfer, m_prv_vld} = '0;
    {s_acq, s_stp, s_sw, m_con, m_aut, m_tmode} = '0;
    {m_prv, m_tmask, m_tval, m_cfg_trg} = '0;
    {m_cfg_pre, m_cfg_pst, m_pre, m_pst} = '0;
    last_out   = '0;
    repeat (2) @(posedge sti);
    @(negedge sti);
    ctl_rst = 1'b0;

    // 1: register access
    begin_test();
    if (dout_valid !== 1'b0 || irq !== 1'b0) begin
      show_problem("dout_valid or irq high after reset");
    end
    read_check(`LA_A_STAT, "STAT", 32'h0);
    read_check(`LA_A_TACQ, "TACQ", 32'h0);
    reg_write(`LA_A_CFG, 32'hB);
    read_check(`LA_A_CFG, "CFG", 32'hB);
    reg_write(`LA_A_TCFG, 32'h0001_5A3C);
    read_check(`LA_A_TCFG, "TCFG", 32'h0001_5A3C);
    reg_write(`LA_A_PRE, 32'h1234);
    read_check(`LA_A_PRE, "PRE", 32'h1234);
    reg_write(`LA_A_PST, 32'hBEEF);
    read_check(`LA_A_PST, "PST", 32'hBEEF);
    apb_access(1'b0, 8'h3C, 32'd0, rd, err);
    if (err !== 1'b1) begin
      show_mismatch("pslverr", {31'd0, err}, 32'd1);
    end
    apb_access(1'b1, `LA_A_STAT, 32'h3, rd, err);
    if (err !== 1'b1) begin
      show_mismatch("pslverr", {31'd0, err}, 32'd1);
    end
    read_check(`LA_A_STAT, "STAT", 32'h0);
    reg_read(`LA_A_TNOW, t0);
    reg_read(`LA_A_TNOW, rd);
    if (!(rd > t0)) begin
      show_problem("TNOW did not increase between two reads");
    end
    end_test(1, "registers");

    // 2: pattern F0/A0, pre 5, post 8
    begin_test();
    reg_write(`LA_A_IRQ, 32'h3);
    reg_write(`LA_A_TCFG, 32'h0000_F0A0);
    reg_write(`LA_A_CFG, 32'h1);
    reg_write(`LA_A_PRE, 32'd5);
    reg_write(`LA_A_PST, 32'd8);
    bp_on  = 1'b1;
    gen_on = 1'b1;
    reg_write(`LA_A_CTRL, 32'h1);
    wait_running();
    wait_stopped();
    drain_stream();
    read_check(`LA_A_SPRE, "SPRE", {16'd0, m_pre});
    read_check(`LA_A_SPST, "SPST", 32'd8);
    read_check(`LA_A_STAT, "STAT", 32'h2);
    check_record();
    check_stamps();
    read_check(`LA_A_IRQ, "IRQ", 32'h3);
    if (irq !== 1'b1) begin
      show_mismatch("irq", {31'd0, irq}, 32'd1);
    end
    reg_write(`LA_A_IRQ, 32'h3);
    tick();
    if (irq !== 1'b0) begin
      show_mismatch("irq", {31'd0, irq}, 32'd0);
    end
    end_test(2, "pattern trigger");

    // 3: rising edge on bit 3, pre 4, post 3
    begin_test();
    reg_write(`LA_A_TCFG, 32'h0001_0808);
    reg_write(`LA_A_PRE, 32'd4);
    reg_write(`LA_A_PST, 32'd3);
    gen_on = 1'b1;
    reg_write(`LA_A_CTRL, 32'h1);
    wait_running();
    wait_stopped();
    drain_stream();
    reg_read(`LA_A_SPRE, rd);
    if (rd !== {16'd0, m_pre}) begin
      show_mismatch("SPRE", rd, {16'd0, m_pre});
    end
    // pre count has to be met before the edge can fire
    if (rd < 32'd4) begin
      show_problem("trigger before the pre-trigger count was met");
    end
    read_check(`LA_A_SPST, "SPST", 32'd3);
    if (n_out != m_pre + 3) begin
      show_mismatch("output count", n_out, m_pre + 3);
    end
    check_record();
    check_stamps();
    read_check(`LA_A_STAT, "STAT", 32'h2);
    reg_write(`LA_A_IRQ, 32'h3);
    end_test(3, "edge trigger");

    // 4: automatic and continuous, software stop
    begin_test();
    reg_write(`LA_A_CFG, 32'hC);
    reg_write(`LA_A_PRE, 32'd0);
    gen_on = 1'b1;
    reg_write(`LA_A_CTRL, 32'h1);
    wait_running();
    repeat (50) tick();
    reg_write(`LA_A_CTRL, 32'h2);
    wait_stopped();
    drain_stream();
    check_record();
    // triggered from the start, every sample is post trigger
    read_check(`LA_A_SPST, "SPST", m_nacq);
    reg_read(`LA_A_TACQ, t0);
    reg_read(`LA_A_TSTP, rd);
    if (!(t0 < rd)) begin
      show_problem($sformatf("stop time %0d not after start time %0d", rd, t0));
    end
    check_stamps();
    end_test(4, "software stop");

    // 5: input last ends the record
    begin_test();
    gen_on = 1'b1;
    reg_write(`LA_A_CTRL, 32'h1);
    wait_running();
    repeat (20) tick();
    last_req = 1'b1;
    wait_stopped();
    n_idle = 0;
    // samples after the stop are accepted and dropped
    repeat (20) tick();
    drain_stream();
    check_record();
    if (last_out.data !== last_data) begin
      show_mismatch("dout.data", {24'd0, last_out.data}, {24'd0, last_data});
    end
    if (n_idle == 0) begin
      show_problem("no samples offered after the stop");
    end
    end_test(5, "input last");

    // 6: stream integrity over 2 to 5
    begin_test();
    if (stream_errs != 0) begin
      show_problem("stream mismatches seen under back-pressure");
    end
    if (n_bp_all == 0) begin
      show_problem("dout_ready never held off a valid sample");
    end
    if (n_out_all == 0) begin
      show_problem("no samples came out in tests 2 to 5");
    end
    end_test(6, "back-pressure");

    $display("summary: %0d tests, %0d ok, %0d failing, %0d errors, %0d cycles",
             tests_ok + tests_bad, tests_ok, tests_bad, errs, cyc);
    if (errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: la.f
+incdir+.
la_pkg.sv
la_trg.sv
la_acq.sv
la_regs.sv
la_top.sv
la_tb.sv

// File: Bender.yml
package:
  name: la

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - la_pkg.sv
      - la_trg.sv
      - la_acq.sv
      - la_regs.sv
      - la_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - la_tb.sv
